//--- hdl/lookup_pkg.sv
// shared widths, types and control layout; tables hold 16 entries, control beats are 64 bits
`default_nettype none

package lookup_pkg;

    // table geometry
    localparam int TBL_DEPTH  = 16;
    localparam int TBL_ADDR_W = 4;

    typedef logic [31:0] key_t;
    typedef logic [63:0] action_t;
    typedef logic [63:0] phv_t;
    typedef logic [7:0]  tbl_index_t;
    typedef logic [63:0] ctrl_data_t;

    typedef struct packed {
        ctrl_data_t data;
        logic [7:0] keep;
        logic       last;
        logic       valid;
    } ctrl_beat_t;

    typedef struct packed {
        key_t key;
        key_t mask;
        phv_t phv;
    } lookup_req_t;

    typedef struct packed {
        action_t action;
        phv_t    phv;
    } lookup_resp_t;

    // control header fields, bit offsets into the beat
    localparam int FLAG_POS   = 48;
    localparam int FLAG_W     = 16;
    localparam int MOD_ID_POS = 40;
    localparam int MOD_ID_W   = 8;
    localparam int RESV_POS   = 36;
    localparam int RESV_W     = 4;
    localparam int INDEX_POS  = 28;

    localparam logic [FLAG_W-1:0] CTRL_FLAG = 16'hf2f1;
    localparam logic [RESV_W-1:0] RESV_CAM  = 4'h0;

    // returned on a CAM miss
    localparam action_t DEFAULT_ACTION = 64'h3f;

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_WAIT_MATCH,
        LK_WAIT_ACTION,
        LK_DELIVER
    } lookup_state_t;

    typedef enum logic [1:0] {
        CT_IDLE,
        CT_CAM_ENTRY,
        CT_ACT_ENTRY,
        CT_FORWARD
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/lookup_cam.sv
// 16-entry CAM; mask bit 1 means don't care, lowest matching index wins, no entry is ever cleared
`default_nettype none

module lookup_cam (
    input  wire                               clk,
    input  wire                               rst_n,

    input  wire                               key_valid,
    input  wire lookup_pkg::key_t             key,
    input  wire lookup_pkg::key_t             mask,

    input  wire                               wr_en,
    input  wire lookup_pkg::tbl_index_t       wr_index,
    input  wire lookup_pkg::key_t             wr_key,

    output logic                              match,
    output logic [lookup_pkg::TBL_ADDR_W-1:0] match_index
);
    import lookup_pkg::*;

    key_t                  keys [TBL_DEPTH];
    logic [TBL_DEPTH-1:0]  entry_valid;
    logic [TBL_DEPTH-1:0]  hit_vec;
    logic                  any_hit;
    logic [TBL_ADDR_W-1:0] first_hit;

    // stored keys
    always_ff @(posedge clk) begin
        if (wr_en) begin
            keys[wr_index[TBL_ADDR_W-1:0]] <= wr_key;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr_en) begin
            entry_valid[wr_index[TBL_ADDR_W-1:0]] <= 1'b1;
        end
    end

    // masked compare per entry
    always_comb begin
        for (int i = 0; i < TBL_DEPTH; i++) begin
            hit_vec[i] = entry_valid[i] && (((keys[i] ^ key) & ~mask) == '0);
        end
    end

    // scan downwards so the lowest hit is the one that sticks
    always_comb begin
        any_hit   = 1'b0;
        first_hit = '0;
        for (int i = TBL_DEPTH - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                any_hit   = 1'b1;
                first_hit = TBL_ADDR_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match       <= 1'b0;
            match_index <= '0;
        end else if (key_valid) begin
            match       <= any_hit;
            match_index <= first_hit;
        end
    end

endmodule

`default_nettype wire

//--- hdl/action_ram.sv
// 16 x 64 action memory; contents are undefined until written, read data lags rd_index by one cycle
`default_nettype none

module action_ram (
    input  wire                               clk,

    input  wire                               wr_en,
    input  wire lookup_pkg::tbl_index_t       wr_index,
    input  wire lookup_pkg::action_t          wr_action,

    input  wire [lookup_pkg::TBL_ADDR_W-1:0]  rd_index,
    output lookup_pkg::action_t               rd_action
);
    import lookup_pkg::*;

    action_t mem [TBL_DEPTH];

    // only the low address bits reach the memory
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index[TBL_ADDR_W-1:0]] <= wr_action;
        end
    end

    // read port runs every cycle
    always_ff @(posedge clk) begin
        rd_action <= mem[rd_index];
    end

endmodule

`default_nettype wire

//--- hdl/lookup_ctrl.sv
// control writer; the control stream never stalls, index wraps at 16 entries, one header beat per packet
`default_nettype none

module lookup_ctrl #(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] LOOKUP_ID = 3'd2
) (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire lookup_pkg::ctrl_beat_t  ctrl_in,
    output lookup_pkg::ctrl_beat_t       ctrl_out,

    output logic                         cam_wr_en,
    output logic                         act_wr_en,
    output lookup_pkg::tbl_index_t       wr_index,
    output lookup_pkg::ctrl_data_t       wr_data
);
    import lookup_pkg::*;

    logic [FLAG_W-1:0]   hdr_flag;
    logic [MOD_ID_W-1:0] hdr_mod_id;
    logic [RESV_W-1:0]   hdr_resv;
    tbl_index_t          hdr_index;
    logic                hdr_ours;

    ctrl_state_t         state;
    tbl_index_t          cur_index;
    logic                fwd_valid;

    ctrl_data_t          data_q;
    logic [7:0]          keep_q;
    logic                last_q;

    // header decode, only meaningful in idle
    assign hdr_flag   = ctrl_in.data[FLAG_POS +: FLAG_W];
    assign hdr_mod_id = ctrl_in.data[MOD_ID_POS +: MOD_ID_W];
    assign hdr_resv   = ctrl_in.data[RESV_POS +: RESV_W];
    assign hdr_index  = ctrl_in.data[INDEX_POS +: $bits(tbl_index_t)];

    assign hdr_ours = (hdr_flag == CTRL_FLAG) && (hdr_mod_id == {STAGE_ID, LOOKUP_ID});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CT_IDLE;
            cur_index <= '0;
            cam_wr_en <= 1'b0;
            act_wr_en <= 1'b0;
            fwd_valid <= 1'b0;
        end else begin
            // strobes last a single cycle
            cam_wr_en <= 1'b0;
            act_wr_en <= 1'b0;
            fwd_valid <= 1'b0;
            if (ctrl_in.valid) begin
                case (state)
                    CT_IDLE: begin
                        if (hdr_ours) begin
                            // a header that is also last carries no entries
                            if (!ctrl_in.last) begin
                                cur_index <= hdr_index;
                                if (hdr_resv == RESV_CAM) begin
                                    state <= CT_CAM_ENTRY;
                                end else begin
                                    state <= CT_ACT_ENTRY;
                                end
                            end
                        end else begin
                            fwd_valid <= 1'b1;
                            if (!ctrl_in.last) begin
                                state <= CT_FORWARD;
                            end
                        end
                    end
                    CT_CAM_ENTRY: begin
                        cam_wr_en <= 1'b1;
                        cur_index <= cur_index + 8'd1;
                        if (ctrl_in.last) begin
                            state <= CT_IDLE;
                        end
                    end
                    CT_ACT_ENTRY: begin
                        act_wr_en <= 1'b1;
                        cur_index <= cur_index + 8'd1;
                        if (ctrl_in.last) begin
                            state <= CT_IDLE;
                        end
                    end
                    CT_FORWARD: begin
                        fwd_valid <= 1'b1;
                        if (ctrl_in.last) begin
                            state <= CT_IDLE;
                        end
                    end
                    default: begin
                        state <= CT_IDLE;
                    end
                endcase
            end
        end
    end

    // beat payload, shared by forwarding and table writes
    always_ff @(posedge clk) begin
        if (ctrl_in.valid) begin
            data_q   <= ctrl_in.data;
            keep_q   <= ctrl_in.keep;
            last_q   <= ctrl_in.last;
            wr_index <= cur_index;
        end
    end

    assign wr_data  = data_q;
    assign ctrl_out = '{data: data_q, keep: keep_q, last: last_q, valid: fwd_valid};

endmodule

`default_nettype wire

//--- hdl/lookup_fsm.sv
// lookup sequencer; one request in flight, hits and misses both wait for ready_in before delivery
`default_nettype none

module lookup_fsm (
    input  wire                               clk,
    input  wire                               rst_n,

    input  wire lookup_pkg::lookup_req_t      req,
    input  wire                               key_valid,
    output logic                              ready_out,

    input  wire                               match,
    input  wire [lookup_pkg::TBL_ADDR_W-1:0]  match_index,

    output logic [lookup_pkg::TBL_ADDR_W-1:0] rd_index,
    input  wire lookup_pkg::action_t          rd_action,

    output lookup_pkg::lookup_resp_t          resp,
    output logic                              action_valid,
    input  wire                               ready_in
);
    import lookup_pkg::*;

    lookup_state_t state;
    logic          accept;
    phv_t          phv_reg;
    action_t       result;

    assign accept = key_valid && ready_out;

    // CAM result is valid in wait_match, the RAM sees it the same cycle
    assign rd_index = match_index;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= LK_IDLE;
            ready_out    <= 1'b1;
            action_valid <= 1'b0;
        end else begin
            action_valid <= 1'b0;
            case (state)
                LK_IDLE: begin
                    if (accept) begin
                        ready_out <= 1'b0;
                        state     <= LK_WAIT_MATCH;
                    end
                end
                LK_WAIT_MATCH: begin
                    // a miss skips the RAM read
                    if (match) begin
                        state <= LK_WAIT_ACTION;
                    end else begin
                        state <= LK_DELIVER;
                    end
                end
                LK_WAIT_ACTION: begin
                    state <= LK_DELIVER;
                end
                LK_DELIVER: begin
                    if (ready_in) begin
                        action_valid <= 1'b1;
                        ready_out    <= 1'b1;
                        state        <= LK_IDLE;
                    end
                end
                default: begin
                    state <= LK_IDLE;
                end
            endcase
        end
    end

    // result path; resp only changes with action_valid
    always_ff @(posedge clk) begin
        case (state)
            LK_IDLE: begin
                if (accept) begin
                    phv_reg <= req.phv;
                end
            end
            LK_WAIT_MATCH: begin
                if (!match) begin
                    result <= DEFAULT_ACTION;
                end
            end
            LK_WAIT_ACTION: begin
                result <= rd_action;
            end
            LK_DELIVER: begin
                if (ready_in) begin
                    resp <= '{action: result, phv: phv_reg};
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/lookup_engine.sv
// match-action stage top; STAGE_ID and LOOKUP_ID select which control headers program these tables
`default_nettype none

module lookup_engine #(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] LOOKUP_ID = 3'd2
) (
    input  wire                            clk,
    input  wire                            rst_n,

    // lookup request
    input  wire lookup_pkg::lookup_req_t   req,
    input  wire                            key_valid,
    output logic                           ready_out,

    // lookup result
    output lookup_pkg::lookup_resp_t       resp,
    output logic                           action_valid,
    input  wire                            ready_in,

    // control stream
    input  wire lookup_pkg::ctrl_beat_t    ctrl_in,
    output lookup_pkg::ctrl_beat_t         ctrl_out
);
    import lookup_pkg::*;

    logic                  match;
    logic [TBL_ADDR_W-1:0] match_index;
    logic [TBL_ADDR_W-1:0] rd_index;
    action_t               rd_action;

    logic                  cam_wr_en;
    logic                  act_wr_en;
    tbl_index_t            wr_index;
    ctrl_data_t            wr_data;

    lookup_fsm lookup_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .key_valid    (key_valid),
        .ready_out    (ready_out),
        .match        (match),
        .match_index  (match_index),
        .rd_index     (rd_index),
        .rd_action    (rd_action),
        .resp         (resp),
        .action_valid (action_valid),
        .ready_in     (ready_in)
    );

    // CAM keys live in the low half of an entry beat
    lookup_cam lookup_cam_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_valid   (key_valid),
        .key         (req.key),
        .mask        (req.mask),
        .wr_en       (cam_wr_en),
        .wr_index    (wr_index),
        .wr_key      (wr_data[$bits(key_t)-1:0]),
        .match       (match),
        .match_index (match_index)
    );

    action_ram action_ram_inst (
        .clk       (clk),
        .wr_en     (act_wr_en),
        .wr_index  (wr_index),
        .wr_action (wr_data),
        .rd_index  (rd_index),
        .rd_action (rd_action)
    );

    lookup_ctrl #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) lookup_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl_in   (ctrl_in),
        .ctrl_out  (ctrl_out),
        .cam_wr_en (cam_wr_en),
        .act_wr_en (act_wr_en),
        .wr_index  (wr_index),
        .wr_data   (wr_data)
    );

endmodule

`default_nettype wire

//--- testbench/lookup_checker.sv
// scoreboard; assumes table writes have landed before a lookup that depends on them is accepted
`default_nettype none

module lookup_checker #(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] LOOKUP_ID = 3'd2
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire lookup_pkg::lookup_req_t  req,
    input  wire                           key_valid,
    input  wire                           ready_out,
    input  wire lookup_pkg::lookup_resp_t resp,
    input  wire                           action_valid,
    input  wire                           ready_in,
    input  wire lookup_pkg::ctrl_beat_t   ctrl_in,
    input  wire lookup_pkg::ctrl_beat_t   ctrl_out,
    input  wire [3:0]                     test_id,
    output int                            value_errors,
    output int                            protocol_errors,
    output int                            pending
);
    import lookup_pkg::*;

    localparam logic [7:0] OUR_ID = {STAGE_ID, LOOKUP_ID};
    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_CAM  = 2'd1;
    localparam logic [1:0] M_ACT  = 2'd2;
    localparam logic [1:0] M_FWD  = 2'd3;

    // shadow copies of both tables
    key_t                 cam_key [TBL_DEPTH];
    logic [TBL_DEPTH-1:0] cam_valid;
    action_t              act_mem [TBL_DEPTH];

    lookup_resp_t         exp_q [$];
    ctrl_beat_t           fwd_q [$];
    lookup_resp_t         exp_resp;
    ctrl_beat_t           exp_beat;
    logic [1:0]           mode;
    tbl_index_t           idx;
    logic                 busy;
    logic                 after_reset;
    logic                 ready_in_q;

    // lowest valid entry whose unmasked bits agree, else the miss action
    function automatic action_t reference_action(input key_t key, input key_t mask);
        action_t act;
        logic    found;
        act   = DEFAULT_ACTION;
        found = 1'b0;
        for (int i = 0; i < TBL_DEPTH; i++) begin
            if (!found && cam_valid[i] && ((cam_key[i] | mask) == (key | mask))) begin
                act   = act_mem[i];
                found = 1'b1;
            end
        end
        return act;
    endfunction

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "reset";
            4'd2:    return "miss_empty";
            4'd3:    return "program_hit";
            4'd4:    return "mask_priority";
            4'd5:    return "backpressure";
            4'd6:    return "forwarding";
            default: return "unknown";
        endcase
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            cam_valid       = '0;
            mode            = M_IDLE;
            busy            = 1'b0;
            after_reset     = 1'b1;
            value_errors    = 0;
            protocol_errors = 0;
            exp_q.delete();
            fwd_q.delete();
        end else begin
            if (after_reset) begin
                after_reset = 1'b0;
                if ({ready_out, action_valid, ctrl_out.valid} !== 3'b100) begin
                    value_errors++;
                    $display("CHECK FAILED %s outputs: expected %b actual %b",
                             test_name(test_id), 3'b100,
                             {ready_out, action_valid, ctrl_out.valid});
                end
            end

            // delivery
            if (action_valid) begin
                // ready_in as seen at the edge that set action_valid
                if (!ready_in_q) begin
                    protocol_errors++;
                    $display("action_valid was set while ready_in was low");
                end
                if (exp_q.size() == 0) begin
                    protocol_errors++;
                    $display("action_valid was set with no request outstanding");
                end else begin
                    exp_resp = exp_q.pop_front();
                    if (resp !== exp_resp) begin
                        value_errors++;
                        $display("CHECK FAILED %s resp: expected %h actual %h",
                                 test_name(test_id), exp_resp, resp);
                    end
                end
                busy = 1'b0;
            end else if (busy && ready_out) begin
                protocol_errors++;
                $display("ready_out rose before the result was delivered");
            end

            // acceptance
            if (key_valid && ready_out) begin
                exp_resp.action = reference_action(req.key, req.mask);
                exp_resp.phv    = req.phv;
                exp_q.push_back(exp_resp);
                busy = 1'b1;
            end

            if (ctrl_out.valid) begin
                if (fwd_q.size() == 0) begin
                    protocol_errors++;
                    $display("ctrl_out carried a beat that should not have been forwarded");
                end else begin
                    exp_beat = fwd_q.pop_front();
                    if (ctrl_out !== exp_beat) begin
                        value_errors++;
                        $display("CHECK FAILED %s ctrl_out: expected %h actual %h",
                                 test_name(test_id), exp_beat, ctrl_out);
                    end
                end
            end

            // decode the control stream
            if (ctrl_in.valid) begin
                case (mode)
                    M_IDLE: begin
                        if (ctrl_in.data[FLAG_POS +: FLAG_W] == CTRL_FLAG
                            && ctrl_in.data[MOD_ID_POS +: MOD_ID_W] == OUR_ID) begin
                            idx  = ctrl_in.data[INDEX_POS +: 8];
                            mode = (ctrl_in.data[RESV_POS +: RESV_W] == 4'h0) ? M_CAM : M_ACT;
                        end else begin
                            fwd_q.push_back(ctrl_in);
                            mode = M_FWD;
                        end
                    end
                    M_CAM: begin
                        cam_key[idx[3:0]]   = ctrl_in.data[31:0];
                        cam_valid[idx[3:0]] = 1'b1;
                        idx = idx + 8'd1;
                    end
                    M_ACT: begin
                        act_mem[idx[3:0]] = ctrl_in.data;
                        idx = idx + 8'd1;
                    end
                    default: begin
                        fwd_q.push_back(ctrl_in);
                    end
                endcase
                // a last beat always ends the packet, header included
                if (ctrl_in.last) begin
                    mode = M_IDLE;
                end
            end
        end
        pending    = exp_q.size() + fwd_q.size();
        ready_in_q = ready_in;
    end

endmodule

`default_nettype wire

//--- testbench/tb_lookup_engine.sv
// testbench top; one lookup in flight at a time, control packets never overlap lookups
`default_nettype none

module tb_lookup_engine;
    import lookup_pkg::*;

    localparam logic [4:0] TB_STAGE_ID  = 5'd3;
    localparam logic [2:0] TB_LOOKUP_ID = 3'd1;
    localparam logic [7:0] OUR_ID       = {TB_STAGE_ID, TB_LOOKUP_ID};
    localparam int         WAIT_LIMIT   = 200;

    logic         clk = 1'b0;
    logic         rst_n;
    lookup_req_t  req;
    logic         key_valid;
    logic         ready_out;
    lookup_resp_t resp;
    logic         action_valid;
    logic         ready_in = 1'b1;
    ctrl_beat_t   ctrl_in;
    ctrl_beat_t   ctrl_out;
    logic [3:0]   test_id;
    logic         bp_on = 1'b0;
    logic [31:0]  lfsr_state = 32'h8549;
    logic [31:0]  bp_lfsr = 32'h8549;
    int           value_errors;
    int           protocol_errors;
    int           pending;
    ctrl_data_t   pkt [$];
    key_t         known_keys [$];

    always #20 clk = ~clk;

    lookup_engine #(
        .STAGE_ID  (TB_STAGE_ID),
        .LOOKUP_ID (TB_LOOKUP_ID)
    ) lookup_engine_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .key_valid    (key_valid),
        .ready_out    (ready_out),
        .resp         (resp),
        .action_valid (action_valid),
        .ready_in     (ready_in),
        .ctrl_in      (ctrl_in),
        .ctrl_out     (ctrl_out)
    );

    lookup_checker #(
        .STAGE_ID  (TB_STAGE_ID),
        .LOOKUP_ID (TB_LOOKUP_ID)
    ) lookup_checker_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .key_valid       (key_valid),
        .ready_out       (ready_out),
        .resp            (resp),
        .action_valid    (action_valid),
        .ready_in        (ready_in),
        .ctrl_in         (ctrl_in),
        .ctrl_out        (ctrl_out),
        .test_id         (test_id),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .pending         (pending)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic key_t random_key();
        logic [63:0] v;
        v = random_bits(32);
        return v[31:0];
    endfunction

    function automatic logic [63:0] random_word();
        return random_bits(64);
    endfunction

    function automatic ctrl_data_t make_header(input logic [7:0] mod_id, input logic [3:0] resv,
                                               input tbl_index_t index, input logic [15:0] flag);
        ctrl_data_t h;
        h = '0;
        h[FLAG_POS +: FLAG_W]               = flag;
        h[MOD_ID_POS +: MOD_ID_W]           = mod_id;
        h[RESV_POS +: RESV_W]               = resv;
        h[INDEX_POS +: $bits(tbl_index_t)]  = index;
        return h;
    endfunction

    // sink stalls about three cycles in four while back-pressure is on
    always @(posedge clk) begin
        if (bp_on) begin
            bp_lfsr = lfsr_next(lfsr_next(bp_lfsr));
            ready_in <= (bp_lfsr[1:0] == 2'b00);
        end else begin
            ready_in <= 1'b1;
        end
    end

    task automatic print_counts();
        $display("errors: value=%0d protocol=%0d pending=%0d",
                 value_errors, protocol_errors, pending);
    endtask

    task automatic fail_timeout(input string what);
        $display("timed out waiting for %s", what);
        print_counts();
        $display("TB FAILED");
        $finish;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk);
        while (pending != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (pending != 0) fail_timeout("outstanding results and forwarded beats");
    endtask

    task automatic do_lookup(input key_t key, input key_t mask, input phv_t phv);
        int n;
        n = 0;
        @(negedge clk);
        while (!ready_out && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!ready_out) fail_timeout("ready_out");
        @(posedge clk);
        req       <= '{key: key, mask: mask, phv: phv};
        key_valid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (ready_out && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ready_out) fail_timeout("request acceptance");
        @(posedge clk);
        key_valid <= 1'b0;
    endtask

    // random don't-care bits, key flipped only where they allow
    task automatic masked_lookup(input key_t base);
        key_t mask;
        mask = random_key() & random_key() & random_key();
        do_lookup(base ^ (random_key() & mask), mask, random_word());
    endtask

    task automatic send_pkt();
        logic [63:0] v;
        for (int i = 0; i < pkt.size(); i++) begin
            v = random_bits(8);
            @(posedge clk);
            ctrl_in <= '{data: pkt[i], keep: v[7:0], last: (i == pkt.size() - 1), valid: 1'b1};
        end
        @(posedge clk);
        ctrl_in <= '0;
        pkt.delete();
        wait_drain();
    endtask

    task automatic program_cam(input tbl_index_t start, input int n);
        key_t k;
        pkt.push_back(make_header(OUR_ID, 4'h0, start, CTRL_FLAG));
        for (int i = 0; i < n; i++) begin
            k = random_key();
            known_keys.push_back(k);
            // upper half is not part of the key
            pkt.push_back({random_key(), k});
        end
        send_pkt();
    endtask

    task automatic program_actions(input tbl_index_t start, input int n);
        pkt.push_back(make_header(OUR_ID, 4'h5, start, CTRL_FLAG));
        for (int i = 0; i < n; i++) begin
            pkt.push_back(random_word());
        end
        send_pkt();
    endtask

    initial begin
        rst_n     = 1'b0;
        req       = '0;
        key_valid = 1'b0;
        ctrl_in   = '0;
        test_id   = 4'd1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);

        test_id = 4'd2;
        for (int i = 0; i < 6; i++) begin
            do_lookup(random_key(), random_key() & random_key(), random_word());
        end
        wait_drain();

        test_id = 4'd3;
        program_cam(8'd4, 6);
        program_actions(8'd4, 6);
        // upper index bits ignored, entries 15 then 0
        program_cam(8'h1f, 2);
        program_actions(8'h2f, 2);
        for (int i = 0; i < known_keys.size(); i++) begin
            do_lookup(known_keys[i], '0, random_word());
        end
        do_lookup(random_key(), '0, random_word());
        wait_drain();

        test_id = 4'd4;
        pkt.push_back(make_header(OUR_ID, 4'h0, 8'd12, CTRL_FLAG));
        pkt.push_back(64'h0000_0000_cafe_0000);
        pkt.push_back(64'h0000_0000_cafe_00ff);
        send_pkt();
        program_actions(8'd12, 2);
        do_lookup(32'hcafe_00ff, 32'h0, random_word());
        do_lookup(32'hcafe_00ff, 32'h0000_00ff, random_word());
        // a lower entry that also covers the masked key takes over
        pkt.push_back(make_header(OUR_ID, 4'h0, 8'd2, CTRL_FLAG));
        pkt.push_back(64'h0000_0000_cafe_0001);
        send_pkt();
        program_actions(8'd2, 1);
        do_lookup(32'hcafe_00ff, 32'h0000_00ff, random_word());
        do_lookup(32'hcafe_0000, 32'h0000_0001, random_word());
        known_keys.push_back(32'hcafe_0000);
        known_keys.push_back(32'hcafe_00ff);
        known_keys.push_back(32'hcafe_0001);
        for (int i = 0; i < known_keys.size(); i++) begin
            masked_lookup(known_keys[i]);
        end
        wait_drain();

        test_id = 4'd5;
        bp_on = 1'b1;
        for (int i = 0; i < 15; i++) begin
            if (i % 3 == 2) begin
                do_lookup(random_key(), '0, random_word());
            end else begin
                masked_lookup(known_keys[i % known_keys.size()]);
            end
        end
        wait_drain();
        bp_on = 1'b0;

        test_id = 4'd6;
        pkt.push_back(make_header(OUR_ID ^ 8'h08, 4'h0, 8'd4, CTRL_FLAG));
        pkt.push_back({32'h0, known_keys[1]});
        pkt.push_back(random_word());
        send_pkt();
        pkt.push_back(make_header(OUR_ID, 4'h1, 8'd4, 16'hf2f0));
        pkt.push_back(random_word());
        send_pkt();
        pkt.push_back(make_header(8'hff, 4'h0, 8'd0, CTRL_FLAG));
        send_pkt();
        // header for this stage with no entries
        pkt.push_back(make_header(OUR_ID, 4'h0, 8'd0, CTRL_FLAG));
        send_pkt();
        for (int i = 0; i < known_keys.size(); i++) begin
            do_lookup(known_keys[i], '0, random_word());
        end
        wait_drain();

        print_counts();
        if (value_errors == 0 && protocol_errors == 0 && pending == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lookup_engine.f
hdl/lookup_pkg.sv
hdl/lookup_cam.sv
hdl/action_ram.sv
hdl/lookup_ctrl.sv
hdl/lookup_fsm.sv
hdl/lookup_engine.sv
testbench/lookup_checker.sv
testbench/tb_lookup_engine.sv

//--- Makefile
TOP := tb_lookup_engine

.PHONY: all run lint clean

all: run

obj_dir/$(TOP): lookup_engine.f hdl/*.sv testbench/*.sv
	verilator --binary --timing -f lookup_engine.f --top-module $(TOP) -o $(TOP)

run: obj_dir/$(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only --timing -f lookup_engine.f --top-module $(TOP)

clean:
	rm -rf obj_dir
